// File: common/lsu_defines.svh
/*
 * Width and timing constants for the load/store unit.
 * Included by the package and by any block that needs a raw bound.
 */

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data path
`define LSU_DATA_W   32  // core word and bus data width
`define LSU_BYTES    4   // byte lanes per bus word
`define LSU_OFFSET_W 2   // byte offset bits inside a word

// upper bound on cycles an access may stay on the bus,
// shared by the RTL checks and the testbench timeouts
`define LSU_WAIT_MAX 64

`endif

// File: common/lsu_pkg.sv
/*
 * Shared types of the load/store unit: data words, byte enables,
 * access size and the bus-control state encoding.
 */

`include "lsu_defines.svh"

package lsu_pkg;

  //////////////////////
  // data path types
  //////////////////////

  typedef logic [`LSU_DATA_W-1:0]   word_t;    // data word or byte address
  typedef logic [`LSU_BYTES-1:0]    be_t;      // one enable per byte lane
  typedef logic [`LSU_OFFSET_W-1:0] offset_t;  // byte position in a word

  // access size, same encoding as the core's load/store type field
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  //////////////////////
  // bus control FSM
  //////////////////////

  typedef enum logic [2:0] {
    IDLE          = 3'd0,  // free, takes the next access
    WAIT_GNT_1    = 3'd1,  // part 1 on the bus
    WAIT_GNT_2    = 3'd2,  // part 2 on the bus, part 1 rvalid may still be due
    WAIT_RVALID_1 = 3'd3,  // both granted, part 1 rvalid pending
    WAIT_RVALID_2 = 3'd4   // only the final rvalid pending
  } bus_state_e;

endpackage

// File: lsu/lsu_req_prep.sv
/*
 * Request stage of the load/store unit. Takes one core request, decides
 * whether it splits, and holds both word addresses, byte enables and
 * lane-rotated store data until the bus stage takes them.
 */

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_req_prep (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic                req_we_i,
  input  lsu_pkg::lsu_size_e  req_size_i,
  input  logic                req_sign_ext_i,
  input  lsu_pkg::word_t      req_addr_i,
  input  lsu_pkg::word_t      req_wdata_i,
  output logic                acc_valid_o,
  input  logic                acc_ready_i,
  output logic                acc_split_o,
  output logic                acc_we_o,
  output lsu_pkg::lsu_size_e  acc_size_o,
  output logic                acc_sign_ext_o,
  output lsu_pkg::offset_t    acc_offset_o,
  output lsu_pkg::word_t      acc_addr1_o,
  output lsu_pkg::word_t      acc_addr2_o,
  output lsu_pkg::be_t        acc_be1_o,
  output lsu_pkg::be_t        acc_be2_o,
  output lsu_pkg::word_t      acc_wdata_o
);

  import lsu_pkg::*;

  logic    full_q;          // stage holds an access
  logic    accept;
  logic    split;
  offset_t offset;
  word_t   addr_al;         // word-aligned part 1 address
  be_t     be1, be2;
  word_t   wdata_rot;

  assign offset  = req_addr_i[`LSU_OFFSET_W-1:0];
  assign addr_al = {req_addr_i[`LSU_DATA_W-1:`LSU_OFFSET_W], {`LSU_OFFSET_W{1'b0}}};

  // misaligned word, or half word crossing into the next word
  assign split = ((req_size_i == SIZE_WORD) && (offset != 2'd0)) ||
                 ((req_size_i == SIZE_HALF) && (offset == 2'd3));

  //////////////////////
  // byte enables
  //////////////////////

  always_comb begin
    be2 = 4'b0000;                        // only split sizes use part 2
    unique case (req_size_i)
      SIZE_WORD: begin
        be1 = 4'b1111 << offset;          // 1111 1110 1100 1000
        case (offset)
          2'd1:    be2 = 4'b0001;
          2'd2:    be2 = 4'b0011;
          2'd3:    be2 = 4'b0111;
          default: be2 = 4'b0000;
        endcase
      end
      SIZE_HALF: begin
        be1 = 4'b0011 << offset;          // offset 3 keeps only lane 3
        if (offset == 2'd3) be2 = 4'b0001;
      end
      default:   be1 = 4'b0001 << offset; // byte, one lane
    endcase
  end

  // rotate left by offset so byte 0 of the data lands on the addressed lane
  always_comb begin
    unique case (offset)
      2'd1:    wdata_rot = {req_wdata_i[23:0], req_wdata_i[31:24]};
      2'd2:    wdata_rot = {req_wdata_i[15:0], req_wdata_i[31:16]};
      2'd3:    wdata_rot = {req_wdata_i[7:0],  req_wdata_i[31:8]};
      default: wdata_rot = req_wdata_i;
    endcase
  end

  //////////////////////
  // stage register
  //////////////////////

  assign req_ready_o = !full_q || acc_ready_i;  // empty, or emptying now
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (req_ready_o) begin
      full_q <= req_valid_i;                  // refill or drain
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      acc_split_o    <= split;
      acc_we_o       <= req_we_i;
      acc_size_o     <= req_size_i;
      acc_sign_ext_o <= req_sign_ext_i;
      acc_offset_o   <= offset;
      acc_addr1_o    <= addr_al;
      acc_addr2_o    <= addr_al + `LSU_BYTES;  // next word
      acc_be1_o      <= be1;
      acc_be2_o      <= be2;
      acc_wdata_o    <= wdata_rot;             // same word for both parts
    end
  end

  assign acc_valid_o = full_q;

  // a stalled access keeps all its fields until the bus stage takes it
  a_acc_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (acc_valid_o && !acc_ready_i) |=> acc_valid_o &&
      $stable({acc_split_o, acc_we_o, acc_size_o, acc_sign_ext_o, acc_offset_o,
               acc_addr1_o, acc_addr2_o, acc_be1_o, acc_be2_o, acc_wdata_o}));

endmodule

// File: lsu/lsu_bus_ctrl.sv
/*
 * Bus stage of the load/store unit. Drives one or two word accesses on the
 * req/gnt/rvalid bus, lets part 2 be granted before part 1 returns, and
 * flags the first and the final rvalid for the response stage.
 */

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_bus_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                acc_valid_i,
  output logic                acc_ready_o,
  input  logic                acc_split_i,
  input  logic                acc_we_i,
  input  lsu_pkg::lsu_size_e  acc_size_i,
  input  logic                acc_sign_ext_i,
  input  lsu_pkg::offset_t    acc_offset_i,
  input  lsu_pkg::word_t      acc_addr1_i,
  input  lsu_pkg::word_t      acc_addr2_i,
  input  lsu_pkg::be_t        acc_be1_i,
  input  lsu_pkg::be_t        acc_be2_i,
  input  lsu_pkg::word_t      acc_wdata_i,
  output logic                data_req_o,
  output lsu_pkg::word_t      data_addr_o,
  output logic                data_we_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::word_t      data_wdata_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  logic                data_err_i,
  output logic                part1_rvalid_o,
  output logic                last_rvalid_o,
  output logic                bus_err_o,
  output lsu_pkg::lsu_size_e  size_o,
  output logic                sign_ext_o,
  output logic                we_o,
  output lsu_pkg::offset_t    offset_o
);

  import lsu_pkg::*;

  localparam int unsigned CycW = $clog2(`LSU_WAIT_MAX + 1);

  bus_state_e state_q, state_d;
  logic       acc_take;
  logic       gnt_take;            // request accepted by memory this cycle
  logic [1:0] out_q;               // granted parts still owed an rvalid
  logic       err_q;               // part 1 error, held for the final response
  logic [CycW-1:0] busy_cyc_q;     // cycles since the access left IDLE

  // captured access
  logic  split_q;
  word_t addr1_q, addr2_q;
  be_t   be1_q, be2_q;

  assign acc_ready_o = (state_q == IDLE);
  assign acc_take    = acc_valid_i && acc_ready_o;

  always_ff @(posedge clk_i) begin
    if (acc_take) begin
      split_q      <= acc_split_i;
      we_o         <= acc_we_i;
      size_o       <= acc_size_i;
      sign_ext_o   <= acc_sign_ext_i;
      offset_o     <= acc_offset_i;
      addr1_q      <= acc_addr1_i;
      addr2_q      <= acc_addr2_i;
      be1_q        <= acc_be1_i;
      be2_q        <= acc_be2_i;
      data_wdata_o <= acc_wdata_i;
    end
  end

  //////////////////////
  // FSM
  //////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:          if (acc_valid_i)   state_d = WAIT_GNT_1;
      WAIT_GNT_1:    if (data_gnt_i)    state_d = split_q ? WAIT_GNT_2 : WAIT_RVALID_2;
      WAIT_GNT_2: begin
        // part 1 may have returned already, or returns right now
        if (data_gnt_i) begin
          state_d = (out_q != 2'd0 && !data_rvalid_i) ? WAIT_RVALID_1 : WAIT_RVALID_2;
        end
      end
      WAIT_RVALID_1: if (data_rvalid_i) state_d = WAIT_RVALID_2;
      WAIT_RVALID_2: if (data_rvalid_i) state_d = IDLE;
      default:                          state_d = IDLE;
    endcase
  end

  assign gnt_take = data_req_o && data_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      out_q      <= 2'd0;
      err_q      <= 1'b0;
      busy_cyc_q <= '0;
    end else begin
      state_q <= state_d;
      out_q   <= out_q + {1'b0, gnt_take} - {1'b0, data_rvalid_i};
      if (acc_take) begin
        err_q <= 1'b0;                         // fresh access
      end else if (part1_rvalid_o) begin
        err_q <= err_q | data_err_i;
      end
      busy_cyc_q <= (state_q == IDLE) ? '0 : busy_cyc_q + 1'b1;
    end
  end

  //////////////////////
  // bus and stage 3 outputs
  //////////////////////

  assign data_req_o  = (state_q == WAIT_GNT_1) || (state_q == WAIT_GNT_2);
  assign data_addr_o = (state_q == WAIT_GNT_2) ? addr2_q : addr1_q;
  assign data_be_o   = (state_q == WAIT_GNT_2) ? be2_q   : be1_q;
  assign data_we_o   = we_o;

  // only part 1 can be outstanding in these two states
  assign part1_rvalid_o = data_rvalid_i &&
                          (state_q == WAIT_GNT_2 || state_q == WAIT_RVALID_1);
  assign last_rvalid_o  = data_rvalid_i && (state_q == WAIT_RVALID_2);
  assign bus_err_o      = err_q | data_err_i;  // read with last_rvalid

  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_addr_o[`LSU_OFFSET_W-1:0] == '0));

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, WAIT_GNT_1, WAIT_GNT_2, WAIT_RVALID_1, WAIT_RVALID_2});

  // memory never answers a request it has not granted
  a_rvalid_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> (out_q != 2'd0));

  // every access drains within the bus bound
  a_access_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_cyc_q < `LSU_WAIT_MAX);

endmodule

// File: lsu/lsu_rdata_align.sv
/*
 * Response stage of the load/store unit. Keeps the part 1 read bytes of a
 * split load, rebuilds the loaded value from both words, extends it and
 * drives the response in the cycle of the final rvalid.
 */

`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                part1_rvalid_i,
  input  logic                last_rvalid_i,
  input  logic                bus_err_i,
  input  lsu_pkg::lsu_size_e  size_i,
  input  logic                sign_ext_i,
  input  logic                we_i,
  input  lsu_pkg::offset_t    offset_i,
  input  lsu_pkg::word_t      data_rdata_i,
  output logic                resp_valid_o,
  output lsu_pkg::word_t      resp_rdata_o,
  output logic                resp_err_o,
  output logic                resp_we_o
);

  import lsu_pkg::*;

  logic [31:8] rdata_q;     // upper three bytes of part 1
  word_t       word_al;     // realigned word
  logic [15:0] half;
  logic [7:0]  byte_v;
  word_t       ext;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (part1_rvalid_i) begin
      rdata_q <= data_rdata_i[31:8];
    end
  end

  //////////////////////
  // realignment
  //////////////////////

  // low bytes come from part 1, high bytes from the word now on the bus
  always_comb begin
    unique case (offset_i)
      2'd1:    word_al = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    word_al = {data_rdata_i[15:0], rdata_q[31:16]};
      2'd3:    word_al = {data_rdata_i[23:0], rdata_q[31:24]};
      default: word_al = data_rdata_i;
    endcase
  end

  always_comb begin
    unique case (offset_i)
      2'd1:    half = data_rdata_i[23:8];
      2'd2:    half = data_rdata_i[31:16];
      2'd3:    half = {data_rdata_i[7:0], rdata_q[31:24]};  // split half word
      default: half = data_rdata_i[15:0];
    endcase
  end

  assign byte_v = data_rdata_i[8*offset_i +: 8];  // bytes never split

  // extension by size
  always_comb begin
    unique case (size_i)
      SIZE_WORD: ext = word_al;
      SIZE_HALF: ext = {{16{sign_ext_i & half[15]}}, half};
      default:   ext = {{24{sign_ext_i & byte_v[7]}}, byte_v};
    endcase
  end

  //////////////////////
  // response
  //////////////////////

  assign resp_valid_o = last_rvalid_i;
  assign resp_err_o   = last_rvalid_i & bus_err_i;
  assign resp_we_o    = we_i;
  assign resp_rdata_o = (we_i || bus_err_i) ? '0 : ext;  // nothing to return

endmodule

// File: hw/lsu_top.sv
/*
 * Load/store unit top level. Chains request preparation, bus control
 * and response alignment between the core port and the memory bus.
 */

`timescale 1ns/1ps

module lsu_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // core request port
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic                req_we_i,
  input  lsu_pkg::lsu_size_e  req_size_i,
  input  logic                req_sign_ext_i,
  input  lsu_pkg::word_t      req_addr_i,
  input  lsu_pkg::word_t      req_wdata_i,
  // memory bus
  output logic                data_req_o,
  output lsu_pkg::word_t      data_addr_o,
  output logic                data_we_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::word_t      data_wdata_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  lsu_pkg::word_t      data_rdata_i,
  input  logic                data_err_i,
  // response port, no back-pressure
  output logic                resp_valid_o,
  output lsu_pkg::word_t      resp_rdata_o,
  output logic                resp_err_o,
  output logic                resp_we_o
);

  import lsu_pkg::*;

  // stage 1 -> stage 2
  logic      acc_valid, acc_ready, acc_split, acc_we, acc_sign_ext;
  lsu_size_e acc_size;
  offset_t   acc_offset;
  word_t     acc_addr1, acc_addr2, acc_wdata;
  be_t       acc_be1, acc_be2;

  // stage 2 -> stage 3
  logic      part1_rvalid, last_rvalid, bus_err, sign_ext, we;
  lsu_size_e size;
  offset_t   offset;

  lsu_req_prep lsu_req_prep_inst (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_we_i, .req_size_i, .req_sign_ext_i,
    .req_addr_i, .req_wdata_i,
    .acc_valid_o    (acc_valid),    .acc_ready_i    (acc_ready),
    .acc_split_o    (acc_split),    .acc_we_o       (acc_we),
    .acc_size_o     (acc_size),     .acc_sign_ext_o (acc_sign_ext),
    .acc_offset_o   (acc_offset),
    .acc_addr1_o    (acc_addr1),    .acc_addr2_o    (acc_addr2),
    .acc_be1_o      (acc_be1),      .acc_be2_o      (acc_be2),
    .acc_wdata_o    (acc_wdata)
  );

  lsu_bus_ctrl lsu_bus_ctrl_inst (
    .clk_i, .rst_ni,
    .acc_valid_i    (acc_valid),    .acc_ready_o    (acc_ready),
    .acc_split_i    (acc_split),    .acc_we_i       (acc_we),
    .acc_size_i     (acc_size),     .acc_sign_ext_i (acc_sign_ext),
    .acc_offset_i   (acc_offset),
    .acc_addr1_i    (acc_addr1),    .acc_addr2_i    (acc_addr2),
    .acc_be1_i      (acc_be1),      .acc_be2_i      (acc_be2),
    .acc_wdata_i    (acc_wdata),
    .data_req_o, .data_addr_o, .data_we_o, .data_be_o, .data_wdata_o,
    .data_gnt_i, .data_rvalid_i, .data_err_i,
    .part1_rvalid_o (part1_rvalid), .last_rvalid_o  (last_rvalid),
    .bus_err_o      (bus_err),      .size_o         (size),
    .sign_ext_o     (sign_ext),     .we_o           (we),
    .offset_o       (offset)
  );

  lsu_rdata_align lsu_rdata_align_inst (
    .clk_i, .rst_ni,
    .part1_rvalid_i (part1_rvalid), .last_rvalid_i  (last_rvalid),
    .bus_err_i      (bus_err),      .size_i         (size),
    .sign_ext_i     (sign_ext),     .we_i           (we),
    .offset_i       (offset),
    .data_rdata_i,
    .resp_valid_o, .resp_rdata_o, .resp_err_o, .resp_we_o
  );

endmodule

// File: tests/lsu_checker.sv
/*
 * Scoreboard for the load/store unit. Watches the core, bus and response
 * ports, keeps a byte-wide reference memory and predicts every response.
 */

`timescale 1ns/1ps

module lsu_checker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  input  logic               req_ready_i,
  input  logic               req_we_i,
  input  lsu_pkg::lsu_size_e req_size_i,
  input  logic               req_sign_ext_i,
  input  lsu_pkg::word_t     req_addr_i,
  input  lsu_pkg::word_t     req_wdata_i,
  input  logic               data_req_i,
  input  lsu_pkg::word_t     data_addr_i,
  input  logic               data_we_i,
  input  lsu_pkg::be_t       data_be_i,
  input  lsu_pkg::word_t     data_wdata_i,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_err_i,
  input  logic               resp_valid_i,
  input  lsu_pkg::word_t     resp_rdata_i,
  input  logic               resp_err_i,
  input  logic               resp_we_i,
  output int unsigned        value_errs_o,
  output int unsigned        proto_errs_o,
  output int unsigned        pending_o
);

  import lsu_pkg::*;

  typedef struct packed {
    logic      we;
    lsu_size_e size;
    logic      sext;
    word_t     addr;
    word_t     wdata;
  } req_t;

  req_t        req_q[$];          // accepted, not answered yet
  logic [7:0]  ref_mem [word_t];  // bytes stored so far, by byte address
  int          gnt_cnt = 0;       // parts of the head request granted
  int          rvalid_cnt = 0;    // parts of the head request returned
  logic [1:0]  part_err = '0;     // error per returned part
  int unsigned value_errs = 0;
  int unsigned proto_errs = 0;
  int unsigned pending = 0;

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;
  assign pending_o    = pending;

  //////////////////////
  // access model
  //////////////////////

  function automatic int size_bytes(lsu_size_e size);
    case (size)
      SIZE_WORD: return 4;
      SIZE_HALF: return 2;
      default:   return 1;
    endcase
  endfunction

  // power-up contents, a hash of the word address
  function automatic word_t mem_fill(word_t waddr);
    return (waddr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [7:0] ref_byte(word_t addr);
    word_t w;
    if (ref_mem.exists(addr)) return ref_mem[addr];
    w = mem_fill({addr[31:2], 2'b00});
    return w[8*addr[1:0] +: 8];
  endfunction

  // byte i of an access sits at offset+i, part (offset+i)/4, lane (offset+i)%4
  function automatic be_t part_be(req_t r, int part);
    be_t be;
    int  pos;
    be = '0;
    for (int i = 0; i < size_bytes(r.size); i++) begin
      pos = int'(r.addr[1:0]) + i;
      if (pos / 4 == part) be[pos % 4] = 1'b1;
    end
    return be;
  endfunction

  function automatic word_t part_wdata(req_t r, int part);
    word_t w;
    int    pos;
    w = '0;
    for (int i = 0; i < size_bytes(r.size); i++) begin
      pos = int'(r.addr[1:0]) + i;
      if (pos / 4 == part) w[8*(pos % 4) +: 8] = r.wdata[8*i +: 8];
    end
    return w;
  endfunction

  function automatic word_t lane_mask(be_t be);
    word_t m;
    m = '0;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) m[8*b +: 8] = 8'hff;
    end
    return m;
  endfunction

  // little-endian gather, then zero or sign extension
  function automatic word_t load_value(req_t r);
    word_t v;
    int    n;
    n = size_bytes(r.size);
    v = '0;
    for (int i = 0; i < n; i++) v[8*i +: 8] = ref_byte(r.addr + i);
    if (r.sext && v[8*n-1]) begin
      for (int i = n; i < 4; i++) v[8*i +: 8] = 8'hff;
    end
    return v;
  endfunction

  // an errored part leaves memory untouched
  task automatic apply_store(req_t r);
    int pos;
    for (int i = 0; i < size_bytes(r.size); i++) begin
      pos = int'(r.addr[1:0]) + i;
      if (!part_err[pos / 4]) ref_mem[r.addr + i] = r.wdata[8*i +: 8];
    end
  endtask

  task automatic check_val(string name, word_t exp, word_t act);
    if (exp !== act) begin
      value_errs++;
      $display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
    end
  endtask

  task automatic flag_proto(string what);
    proto_errs++;
    $display("Error at %0t: %s", $time, what);
  endtask

  //////////////////////
  // port monitor
  //////////////////////

  // DUT flops update by NBA, so outputs read here are the pre-edge values
  always @(posedge clk_i) begin
    req_t r;
    int   parts;
    logic err;
    if (rst_ni) begin
      if (data_req_i && data_gnt_i) begin
        if (req_q.size() == 0 || gnt_cnt > 1) begin
          flag_proto("bus request granted with no part left to issue");
        end else begin
          r = req_q[0];
          check_val("data_addr_o", {r.addr[31:2], 2'b00} + 4 * gnt_cnt, data_addr_i);
          check_val("data_be_o", part_be(r, gnt_cnt), data_be_i);
          check_val("data_we_o", r.we, data_we_i);
          if (r.we) begin
            check_val("data_wdata_o", part_wdata(r, gnt_cnt),
                      data_wdata_i & lane_mask(data_be_i));
          end
          gnt_cnt++;
        end
      end
      if (data_rvalid_i) begin
        if (rvalid_cnt >= gnt_cnt) begin
          flag_proto("rvalid arrived with no granted part outstanding");
        end else begin
          part_err[rvalid_cnt] = data_err_i;
          rvalid_cnt++;
        end
      end
      if (resp_valid_i) begin
        if (req_q.size() == 0) begin
          flag_proto("response arrived with no request pending");
        end else begin
          r     = req_q.pop_front();
          parts = (int'(r.addr[1:0]) + size_bytes(r.size) > 4) ? 2 : 1;
          if (gnt_cnt != parts || rvalid_cnt != parts) begin
            flag_proto($sformatf("access at %h used %0d grants, %0d rvalids, wanted %0d",
                                 r.addr, gnt_cnt, rvalid_cnt, parts));
          end
          err = part_err[0] | ((parts == 2) & part_err[1]);
          check_val("resp_err_o", err, resp_err_i);
          check_val("resp_we_o", r.we, resp_we_i);
          check_val("resp_rdata_o", (r.we || err) ? 32'h0 : load_value(r), resp_rdata_i);
          if (r.we) apply_store(r);
          gnt_cnt    = 0;
          rvalid_cnt = 0;
          part_err   = '0;
        end
      end
      if (req_valid_i && req_ready_i) begin
        r.we    = req_we_i;
        r.size  = req_size_i;
        r.sext  = req_sign_ext_i;
        r.addr  = req_addr_i;
        r.wdata = req_wdata_i;
        req_q.push_back(r);
      end
      pending = req_q.size();
    end
  end

endmodule

// File: tests/tb_lsu.sv
/*
 * Testbench for the load/store unit. Sends random loads and stores, answers
 * the bus with random grant and rvalid delays and injected errors, and lets
 * lsu_checker score every response.
 */

`timescale 1ns/1ps

`include "lsu_defines.svh"

module tb_lsu;

  import lsu_pkg::*;

  localparam int NumReqs = 400;

  logic      clk, rst_n;
  logic      req_valid, req_ready, req_we, req_sign_ext;
  lsu_size_e req_size;
  word_t     req_addr, req_wdata;
  logic      data_req, data_we, data_gnt, data_rvalid, data_err;
  be_t       data_be;
  word_t     data_addr, data_wdata, data_rdata;
  logic      resp_valid, resp_err, resp_we;
  word_t     resp_rdata;

  int unsigned value_errs, proto_errs, pending;
  int unsigned timeouts = 0;
  integer      seed = 32'hfe2d;

  word_t mem [word_t];     // bus-side memory, by word address
  word_t rsp_data_q[$];    // granted parts waiting for rvalid
  logic  rsp_err_q[$];
  int    gnt_wait, rsp_wait;

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // power-up contents hashed from the word address
  function automatic word_t mem_fill(word_t waddr);
    return (waddr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  task automatic finish_run();
    $display("errors: %0d value, %0d protocol, %0d timeout",
             value_errs, proto_errs, timeouts);
    if (value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  //////////////////////
  // core side
  //////////////////////

  // address window of 64 bytes so stores and loads hit the same words
  task automatic send_req();
    int cyc;
    @(negedge clk);
    req_valid    = 1'b1;
    req_we       = (rand_below(2) != 0);
    req_size     = lsu_size_e'(rand_below(3));
    req_sign_ext = (rand_below(2) != 0);
    req_addr     = 32'h0000_2000 + rand_below(64);
    req_wdata    = $random(seed);
    cyc = 0;
    while (!req_ready && cyc < `LSU_WAIT_MAX) begin  // ready moves on posedge only
      @(negedge clk);
      cyc++;
    end
    if (!req_ready) begin
      timeouts++;
      $display("request to %h was never accepted", req_addr);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    int cyc;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_we       = 1'b0;
    req_size     = SIZE_WORD;
    req_sign_ext = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < NumReqs && timeouts == 0; n++) begin
      send_req();
      if (rand_below(4) == 0) begin   // idle gap
        @(negedge clk);
        req_valid = 1'b0;
        repeat (rand_below(3)) @(negedge clk);
      end
    end
    @(negedge clk);
    req_valid = 1'b0;
    cyc = 0;
    while (pending != 0 && cyc < `LSU_WAIT_MAX) begin
      @(negedge clk);
      cyc++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("%0d responses still missing after the last request", pending);
    end
    finish_run();
  end

  //////////////////////
  // memory responder
  //////////////////////

  // an errored write is dropped, an errored read returns the stale word
  task automatic serve_access();
    word_t w;
    logic  err;
    w   = mem.exists(data_addr) ? mem[data_addr] : mem_fill(data_addr);
    err = (rand_below(16) == 0);
    if (data_we && !err) begin
      for (int b = 0; b < `LSU_BYTES; b++) begin
        if (data_be[b]) w[8*b +: 8] = data_wdata[8*b +: 8];
      end
      mem[data_addr] = w;
    end
    rsp_data_q.push_back(w);
    rsp_err_q.push_back(err);
  endtask

  initial begin
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    data_err    = 1'b0;
    gnt_wait    = rand_below(4);
    rsp_wait    = 0;
    forever begin
      @(negedge clk);
      data_gnt    = 1'b0;
      data_rvalid = 1'b0;
      data_rdata  = '0;
      data_err    = 1'b0;
      if (rsp_data_q.size() != 0) begin  // returned in order 1 to 3 cycles after grant
        if (rsp_wait == 0) begin
          data_rvalid = 1'b1;
          data_rdata  = rsp_data_q.pop_front();
          data_err    = rsp_err_q.pop_front();
          rsp_wait    = rand_below(3);
        end else begin
          rsp_wait--;
        end
      end
      if (data_req) begin
        if (gnt_wait == 0) begin
          data_gnt = 1'b1;
          serve_access();
          gnt_wait = rand_below(4);
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  lsu_top lsu_top_inst (
    .clk_i          (clk),          .rst_ni         (rst_n),
    .req_valid_i    (req_valid),    .req_ready_o    (req_ready),
    .req_we_i       (req_we),       .req_size_i     (req_size),
    .req_sign_ext_i (req_sign_ext), .req_addr_i     (req_addr),
    .req_wdata_i    (req_wdata),
    .data_req_o     (data_req),     .data_addr_o    (data_addr),
    .data_we_o      (data_we),      .data_be_o      (data_be),
    .data_wdata_o   (data_wdata),   .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),  .data_rdata_i   (data_rdata),
    .data_err_i     (data_err),
    .resp_valid_o   (resp_valid),   .resp_rdata_o   (resp_rdata),
    .resp_err_o     (resp_err),     .resp_we_o      (resp_we)
  );

  lsu_checker lsu_checker_inst (
    .clk_i          (clk),          .rst_ni         (rst_n),
    .req_valid_i    (req_valid),    .req_ready_i    (req_ready),
    .req_we_i       (req_we),       .req_size_i     (req_size),
    .req_sign_ext_i (req_sign_ext), .req_addr_i     (req_addr),
    .req_wdata_i    (req_wdata),
    .data_req_i     (data_req),     .data_addr_i    (data_addr),
    .data_we_i      (data_we),      .data_be_i      (data_be),
    .data_wdata_i   (data_wdata),   .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),  .data_err_i     (data_err),
    .resp_valid_i   (resp_valid),   .resp_rdata_i   (resp_rdata),
    .resp_err_i     (resp_err),     .resp_we_i      (resp_we),
    .value_errs_o   (value_errs),   .proto_errs_o   (proto_errs),
    .pending_o      (pending)
  );

endmodule

// File: filelist.f
+incdir+common
common/lsu_pkg.sv
lsu/lsu_req_prep.sv
lsu/lsu_bus_ctrl.sv
lsu/lsu_rdata_align.sv
hw/lsu_top.sv
tests/lsu_checker.sv
tests/tb_lsu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator.
# Exits non-zero unless the simulation log reports a pass.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_lsu -o sim_lsu

./obj_dir/sim_lsu 2>&1 | tee sim.log

if grep -q "^test passed$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
